/* core_mem_pkg.sv */
package core_mem_pkg;

    // data and address width
    localparam int xlen = 32;

    // access-size codes on every mask port, code 3 decodes as a word
    localparam logic [1:0] size_byte = 2'd0;
    localparam logic [1:0] size_half = 2'd1;
    localparam logic [1:0] size_word = 2'd2;

    localparam int reg_addr_width  = 5;
    localparam int csr_addr_width  = 12;

    // burst carries length field plus one beats
    localparam int burst_len_width = 8;
    localparam int err_type_width  = 4;

    // one memory word, seen as byte lanes or halfword lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } mem_word_t;

endpackage

/* data_ram.sv */
`timescale 1ns/1ps

module data_ram import core_mem_pkg::*; #(
    parameter int ram_words   = 1024,
    parameter int ram_latency = 2
) (
    input  logic                         clock,
    input  logic                         reset,

    input  logic                         req,
    input  logic                         we,
    input  logic [$clog2(ram_words)-1:0] index,
    input  logic [xlen-1:0]              wdata,
    input  logic [3:0]                   be,

    output logic                         ack,
    output logic [xlen-1:0]              rdata
);

    logic [xlen-1:0]        mem [ram_words];
    logic [ram_latency-1:0] ack_pipe;
    logic [xlen-1:0]        data_pipe [ram_latency];

    assign ack   = ack_pipe[ram_latency-1];
    assign rdata = data_pipe[ram_latency-1];

    // array access, read returns the old word on a write
    always_ff @(posedge clock) begin
        if (req && we) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem[index][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
        data_pipe[0] <= mem[index];
        for (int i = 1; i < ram_latency; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    // acknowledge delay line
    always_ff @(posedge clock) begin
        if (reset) begin
            ack_pipe <= '0;
        end else begin
            ack_pipe[0] <= req;
            for (int i = 1; i < ram_latency; i++) begin
                ack_pipe[i] <= ack_pipe[i-1];
            end
        end
    end

    a_single_outstanding: assert property (
        @(posedge clock) disable iff (reset) req |-> !(|ack_pipe));

endmodule

/* load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit import core_mem_pkg::*; #(
    parameter int ram_words   = 1024,
    parameter int ram_latency = 2
) (
    input  logic                         clock,
    input  logic                         reset,

    input  logic                         rvalid,
    input  logic [xlen-1:0]              raddr,
    input  logic [burst_len_width-1:0]   rlen,
    input  logic                         burst,
    input  logic                         rsign,
    input  logic [1:0]                   rmask,
    output logic                         rready,
    output logic [xlen-1:0]              rdata,

    input  logic                         wvalid,
    input  logic [xlen-1:0]              waddr,
    input  logic [xlen-1:0]              wdata,
    input  logic [1:0]                   wmask,
    output logic                         wready,

    output logic                         ram_req,
    output logic                         ram_we,
    output logic [$clog2(ram_words)-1:0] ram_index,
    output logic [xlen-1:0]              ram_wdata,
    output logic [3:0]                   ram_be,
    input  logic                         ram_ack,
    input  logic [xlen-1:0]              ram_rdata
);

    localparam int index_width = $clog2(ram_words);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_read  = 2'd1;
    localparam logic [1:0] st_write = 2'd2;

    logic [1:0]                 state;
    logic [burst_len_width-1:0] beat_cnt;

    mem_word_t  load_word;
    mem_word_t  store_word;
    logic [3:0] store_be;
    logic [7:0]  lane_b;
    logic [15:0] lane_h;

    assign rready = (state == st_read) & ram_ack;
    assign wready = (state == st_write) & ram_ack;

    // ----------------------------------------------------------------------
    // load lane select and extension
    // ----------------------------------------------------------------------

    assign load_word = ram_rdata;
    assign lane_b    = load_word.bytes[raddr[1:0]];
    assign lane_h    = load_word.halves[raddr[1]];

    always_comb begin
        case (rmask)
            size_byte: rdata = {{24{rsign & lane_b[7]}}, lane_b};
            size_half: rdata = {{16{rsign & lane_h[15]}}, lane_h};
            default:   rdata = load_word;
        endcase
    end

    // store data replicated into every lane, enables pick the right one
    always_comb begin
        case (wmask)
            size_byte: begin
                store_word.bytes = {4{wdata[7:0]}};
                store_be         = 4'b0001 << waddr[1:0];
            end
            size_half: begin
                store_word.halves = {2{wdata[15:0]}};
                store_be          = waddr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                store_word = wdata;
                store_be   = 4'b1111;
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // request FSM, one RAM request per beat
    // ----------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= st_idle;
            ram_req <= 1'b0;
        end else begin
            ram_req <= 1'b0;
            case (state)
                st_idle: begin
                    if (rvalid) begin
                        state   <= st_read;
                        ram_req <= 1'b1;
                    end else if (wvalid) begin
                        state   <= st_write;
                        ram_req <= 1'b1;
                    end
                end
                st_read: begin
                    if (ram_ack) begin
                        if (beat_cnt == '0) begin
                            state <= st_idle;
                        end else begin
                            ram_req <= 1'b1;
                        end
                    end
                end
                st_write: begin
                    if (ram_ack) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // request payload and burst position
    always_ff @(posedge clock) begin
        if (state == st_idle) begin
            ram_we    <= wvalid & ~rvalid;
            ram_index <= rvalid ? raddr[index_width+1:2] : waddr[index_width+1:2];
            ram_wdata <= store_word;
            ram_be    <= store_be;
            beat_cnt  <= burst ? rlen : '0;
        end else if (rready) begin
            beat_cnt  <= beat_cnt - 1'b1;
            ram_index <= ram_index + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // assertions
    // ----------------------------------------------------------------------

    a_half_aligned: assert property (@(posedge clock) disable iff (reset)
        !((rvalid && rmask == size_half && raddr[0]) ||
          (wvalid && wmask == size_half && waddr[0])));

    // RAM answers at its fixed latency
    a_ram_latency: assert property (@(posedge clock) disable iff (reset)
        ram_req |-> ##ram_latency ram_ack);

endmodule

/* mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter import core_mem_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,

    input  logic                      cah_valid,
    input  logic [xlen-1:0]           cah_addr,
    input  logic                      cah_burst,
    input  logic [burst_len_width-1:0] cah_rlen,
    output logic                      cah_ready,
    output logic [xlen-1:0]           cah_data,

    input  logic                      exu_valid,
    output logic                      exu_ready,
    input  logic                      exu_men,

    input  logic [reg_addr_width-1:0] exu_ard,
    input  logic [xlen-1:0]           exu_rd,
    input  logic                      exu_gen,
    input  logic [csr_addr_width-1:0] exu_acsr,
    input  logic [xlen-1:0]           exu_csr,
    input  logic                      exu_sen,
    input  logic                      exu_write,
    input  logic [xlen-1:0]           exu_wdata,
    input  logic [xlen-1:0]           exu_addr,
    input  logic [1:0]                exu_mask,
    input  logic                      exu_rsign,

    output logic                      lsu_rvalid,
    input  logic                      lsu_rready,
    input  logic [xlen-1:0]           lsu_rdata,
    output logic [xlen-1:0]           lsu_raddr,
    output logic [burst_len_width-1:0] lsu_rlen,
    output logic                      lsu_burst,
    output logic                      lsu_rsign,
    output logic [1:0]                lsu_rmask,

    output logic                      lsu_wvalid,
    input  logic                      lsu_wready,
    output logic [xlen-1:0]           lsu_wdata,
    output logic [xlen-1:0]           lsu_waddr,
    output logic [1:0]                lsu_wmask,

    output logic                      reg_valid,
    output logic [reg_addr_width-1:0] reg_addr,
    output logic [xlen-1:0]           reg_data,
    output logic                      csr_valid,
    output logic [csr_addr_width-1:0] csr_addr,
    output logic [xlen-1:0]           csr_data,

    input  logic                      erri,
    input  logic [err_type_width-1:0] errtpi,
    output logic                      erro,
    output logic [err_type_width-1:0] errtpo
);

    // ----------------------------------------------------------------------
    // state and saved operands
    // ----------------------------------------------------------------------

    logic                      working;

    logic                      wvalid;
    logic [xlen-1:0]           waddr;
    logic [xlen-1:0]           wdata;
    logic [1:0]                wmask;

    logic                      rvalid;
    logic [xlen-1:0]           raddr;
    logic [1:0]                rmask;
    logic                      rsign;
    logic [reg_addr_width-1:0] wbaddr;

    logic handsk;
    logic mem_load;
    logic mem_store;
    logic wtok;
    logic rtok;
    logic cache_grant;

    assign handsk      = exu_valid & exu_ready;
    assign mem_load    = handsk & exu_men & ~exu_write;
    assign mem_store   = handsk & exu_men & exu_write;
    assign wtok        = lsu_wvalid & lsu_wready;
    assign rtok        = rvalid & lsu_rready;
    // cache owns the read channel only while nothing is in flight
    assign cache_grant = ~working & cah_valid;

    // ----------------------------------------------------------------------
    // outside ports
    // ----------------------------------------------------------------------

    assign erro   = handsk & erri;
    assign errtpo = errtpi;

    // non-memory ops may slip past a busy cache when error-free
    assign exu_ready = ~working & (~cah_valid | (~exu_men & ~erri));

    assign reg_valid = (handsk & ~exu_men & exu_gen) | rtok;
    assign reg_addr  = rvalid ? wbaddr : exu_ard;
    assign reg_data  = rvalid ? lsu_rdata : exu_rd;

    assign csr_valid = handsk & exu_sen;
    assign csr_addr  = exu_acsr;
    assign csr_data  = exu_csr;

    assign cah_ready = cache_grant & lsu_rready;
    assign cah_data  = cah_ready ? lsu_rdata : '0;

    // read channel, cache fetch is an unsigned word read
    assign lsu_rvalid = cache_grant ? 1'b1 : rvalid;
    assign lsu_raddr  = cache_grant ? cah_addr : raddr;
    assign lsu_rlen   = cache_grant ? cah_rlen : '0;
    assign lsu_burst  = cache_grant ? cah_burst : 1'b0;
    assign lsu_rsign  = cache_grant ? 1'b0 : rsign;
    assign lsu_rmask  = cache_grant ? 2'b11 : rmask;

    assign lsu_wvalid = wvalid;
    assign lsu_waddr  = waddr;
    assign lsu_wdata  = wdata;
    assign lsu_wmask  = wmask;

    // ----------------------------------------------------------------------
    // control
    // ----------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            working <= 1'b0;
            wvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            if (handsk & exu_men) begin
                working <= 1'b1;
            end else if (rtok | wtok) begin
                working <= 1'b0;
            end

            if (mem_store) begin
                wvalid <= 1'b1;
            end else if (wtok) begin
                wvalid <= 1'b0;
            end

            if (mem_load) begin
                rvalid <= 1'b1;
            end else if (rtok) begin
                rvalid <= 1'b0;
            end
        end
    end

    // operand copies, held until the channel completes
    always_ff @(posedge clock) begin
        if (mem_store) begin
            waddr <= exu_addr;
            wdata <= exu_wdata;
            wmask <= exu_mask;
        end
        if (mem_load) begin
            raddr  <= exu_addr;
            rmask  <= exu_mask;
            rsign  <= exu_rsign;
            wbaddr <= exu_ard;
        end
    end

    // ----------------------------------------------------------------------
    // assertions
    // ----------------------------------------------------------------------

    a_one_channel: assert property (
        @(posedge clock) disable iff (reset) !(lsu_rvalid && lsu_wvalid));

    // accepted memory op keeps the execute port closed
    a_busy_blocks_exu: assert property (
        @(posedge clock) disable iff (reset) (handsk && exu_men) |=> !exu_ready);

endmodule

/* mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem import core_mem_pkg::*; #(
    parameter int ram_words   = 1024,
    parameter int ram_latency = 2
) (
    input  logic                       clock,
    input  logic                       reset,

    input  logic                       cah_valid,
    input  logic [xlen-1:0]            cah_addr,
    input  logic                       cah_burst,
    input  logic [burst_len_width-1:0] cah_rlen,
    output logic                       cah_ready,
    output logic [xlen-1:0]            cah_data,

    input  logic                       exu_valid,
    output logic                       exu_ready,
    input  logic                       exu_men,
    input  logic [reg_addr_width-1:0]  exu_ard,
    input  logic [xlen-1:0]            exu_rd,
    input  logic                       exu_gen,
    input  logic [csr_addr_width-1:0]  exu_acsr,
    input  logic [xlen-1:0]            exu_csr,
    input  logic                       exu_sen,
    input  logic                       exu_write,
    input  logic [xlen-1:0]            exu_wdata,
    input  logic [xlen-1:0]            exu_addr,
    input  logic [1:0]                 exu_mask,
    input  logic                       exu_rsign,

    output logic                       reg_valid,
    output logic [reg_addr_width-1:0]  reg_addr,
    output logic [xlen-1:0]            reg_data,
    output logic                       csr_valid,
    output logic [csr_addr_width-1:0]  csr_addr,
    output logic [xlen-1:0]            csr_data,

    input  logic                       erri,
    input  logic [err_type_width-1:0]  errtpi,
    output logic                       erro,
    output logic [err_type_width-1:0]  errtpo
);

    // arbiter to load/store unit
    logic                       lsu_rvalid;
    logic                       lsu_rready;
    logic [xlen-1:0]            lsu_rdata;
    logic [xlen-1:0]            lsu_raddr;
    logic [burst_len_width-1:0] lsu_rlen;
    logic                       lsu_burst;
    logic                       lsu_rsign;
    logic [1:0]                 lsu_rmask;
    logic                       lsu_wvalid;
    logic                       lsu_wready;
    logic [xlen-1:0]            lsu_wdata;
    logic [xlen-1:0]            lsu_waddr;
    logic [1:0]                 lsu_wmask;

    // load/store unit to RAM
    logic                         ram_req;
    logic                         ram_we;
    logic [$clog2(ram_words)-1:0] ram_index;
    logic [xlen-1:0]              ram_wdata;
    logic [3:0]                   ram_be;
    logic                         ram_ack;
    logic [xlen-1:0]              ram_rdata;

    mem_arbiter u_arbiter (
        .clock      (clock),
        .reset      (reset),
        .cah_valid  (cah_valid),
        .cah_addr   (cah_addr),
        .cah_burst  (cah_burst),
        .cah_rlen   (cah_rlen),
        .cah_ready  (cah_ready),
        .cah_data   (cah_data),
        .exu_valid  (exu_valid),
        .exu_ready  (exu_ready),
        .exu_men    (exu_men),
        .exu_ard    (exu_ard),
        .exu_rd     (exu_rd),
        .exu_gen    (exu_gen),
        .exu_acsr   (exu_acsr),
        .exu_csr    (exu_csr),
        .exu_sen    (exu_sen),
        .exu_write  (exu_write),
        .exu_wdata  (exu_wdata),
        .exu_addr   (exu_addr),
        .exu_mask   (exu_mask),
        .exu_rsign  (exu_rsign),
        .lsu_rvalid (lsu_rvalid),
        .lsu_rready (lsu_rready),
        .lsu_rdata  (lsu_rdata),
        .lsu_raddr  (lsu_raddr),
        .lsu_rlen   (lsu_rlen),
        .lsu_burst  (lsu_burst),
        .lsu_rsign  (lsu_rsign),
        .lsu_rmask  (lsu_rmask),
        .lsu_wvalid (lsu_wvalid),
        .lsu_wready (lsu_wready),
        .lsu_wdata  (lsu_wdata),
        .lsu_waddr  (lsu_waddr),
        .lsu_wmask  (lsu_wmask),
        .reg_valid  (reg_valid),
        .reg_addr   (reg_addr),
        .reg_data   (reg_data),
        .csr_valid  (csr_valid),
        .csr_addr   (csr_addr),
        .csr_data   (csr_data),
        .erri       (erri),
        .errtpi     (errtpi),
        .erro       (erro),
        .errtpo     (errtpo)
    );

    load_store_unit #(
        .ram_words   (ram_words),
        .ram_latency (ram_latency)
    ) u_lsu (
        .clock     (clock),
        .reset     (reset),
        .rvalid    (lsu_rvalid),
        .raddr     (lsu_raddr),
        .rlen      (lsu_rlen),
        .burst     (lsu_burst),
        .rsign     (lsu_rsign),
        .rmask     (lsu_rmask),
        .rready    (lsu_rready),
        .rdata     (lsu_rdata),
        .wvalid    (lsu_wvalid),
        .waddr     (lsu_waddr),
        .wdata     (lsu_wdata),
        .wmask     (lsu_wmask),
        .wready    (lsu_wready),
        .ram_req   (ram_req),
        .ram_we    (ram_we),
        .ram_index (ram_index),
        .ram_wdata (ram_wdata),
        .ram_be    (ram_be),
        .ram_ack   (ram_ack),
        .ram_rdata (ram_rdata)
    );

    data_ram #(
        .ram_words   (ram_words),
        .ram_latency (ram_latency)
    ) u_ram (
        .clock (clock),
        .reset (reset),
        .req   (ram_req),
        .we    (ram_we),
        .index (ram_index),
        .wdata (ram_wdata),
        .be    (ram_be),
        .ack   (ram_ack),
        .rdata (ram_rdata)
    );

endmodule

/* mem_subsystem_tb.sv */
`timescale 1ns/1ps

module mem_subsystem_tb import core_mem_pkg::*; ();

    localparam int ram_words   = 1024;
    localparam int ram_latency = 2;
    localparam int period      = 4;
    localparam int num_fill    = 64;
    localparam int num_rand    = 300;
    localparam int max_beats   = 4;
    localparam int timeout_ns  =
        (num_fill + num_rand) * (ram_latency + 2) * max_beats * period + 2000;

    logic                       clock;
    logic                       reset;
    logic                       cah_valid;
    logic [xlen-1:0]            cah_addr;
    logic                       cah_burst;
    logic [burst_len_width-1:0] cah_rlen;
    logic                       cah_ready;
    logic [xlen-1:0]            cah_data;
    logic                       exu_valid;
    logic                       exu_ready;
    logic                       exu_men;
    logic [reg_addr_width-1:0]  exu_ard;
    logic [xlen-1:0]            exu_rd;
    logic                       exu_gen;
    logic [csr_addr_width-1:0]  exu_acsr;
    logic [xlen-1:0]            exu_csr;
    logic                       exu_sen;
    logic                       exu_write;
    logic [xlen-1:0]            exu_wdata;
    logic [xlen-1:0]            exu_addr;
    logic [1:0]                 exu_mask;
    logic                       exu_rsign;
    logic                       reg_valid;
    logic [reg_addr_width-1:0]  reg_addr;
    logic [xlen-1:0]            reg_data;
    logic                       csr_valid;
    logic [csr_addr_width-1:0]  csr_addr;
    logic [xlen-1:0]            csr_data;
    logic                       erri;
    logic [err_type_width-1:0]  errtpi;
    logic                       erro;
    logic [err_type_width-1:0]  errtpo;

    // reference memory, 64 words at the bottom of the RAM
    logic [31:0]               model_mem [64];
    logic [5:0]                op_word;
    logic                      load_busy;
    logic                      store_busy;
    logic [7:0]                busy_cycles;
    logic [31:0]               exp_load;
    logic [reg_addr_width-1:0] exp_rd;
    logic [5:0]                cache_beat;
    logic [7:0]                cache_gap;
    logic [31:0]               cache_exp;
    integer                    seed = 32'h86efb735;

    mem_subsystem #(
        .ram_words   (ram_words),
        .ram_latency (ram_latency)
    ) dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    initial begin
        #(timeout_ns);
        $display("timeout: run did not finish within %0d ns", timeout_ns);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic stop_on_error(input string what);
        $display("FAIL at %0d ns: %s", $time, what);
        $display("SIMULATION FAILED");
        $fatal(1, "check failed");
    endtask

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e3779b1) ^ 32'h3c5a0f96;
    endfunction

    // expected load result from the reference bytes
    function automatic logic [31:0] model_load(input logic [31:0] addr,
                                               input logic [1:0] mask,
                                               input logic sign);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        w = model_mem[addr[7:2]];
        b = w[{addr[1:0], 3'b000} +: 8];
        h = w[{addr[1], 4'b0000} +: 16];
        case (mask)
            size_byte: return {{24{sign & b[7]}}, b};
            size_half: return {{16{sign & h[15]}}, h};
            default:   return w;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // reference model and timing trackers
    // ------------------------------------------------------------------

    assign op_word = exu_addr[7:2];

    always_comb begin
        cache_exp = model_mem[cah_addr[7:2] + cache_beat];
    end

    always @(posedge clock) begin
        if (reset) begin
            load_busy   <= 1'b0;
            store_busy  <= 1'b0;
            busy_cycles <= '0;
            cache_beat  <= '0;
            cache_gap   <= '0;
        end else begin
            if (exu_valid && exu_ready && exu_men) begin
                load_busy   <= !exu_write;
                store_busy  <= exu_write;
                busy_cycles <= 8'd1;
                if (!exu_write) begin
                    exp_load <= model_load(exu_addr, exu_mask, exu_rsign);
                    exp_rd   <= exu_ard;
                end else begin
                    case (exu_mask)
                        size_byte: model_mem[op_word][{exu_addr[1:0], 3'b000} +: 8]
                                       <= exu_wdata[7:0];
                        size_half: model_mem[op_word][{exu_addr[1], 4'b0000} +: 16]
                                       <= exu_wdata[15:0];
                        default:   model_mem[op_word] <= exu_wdata;
                    endcase
                end
            end else if (load_busy && reg_valid) begin
                load_busy <= 1'b0;
            end else if (store_busy && busy_cycles == ram_latency + 2) begin
                store_busy <= 1'b0;
            end else begin
                busy_cycles <= busy_cycles + 8'd1;
            end

            if (!cah_valid) begin
                cache_beat <= '0;
            end else if (cah_ready) begin
                cache_beat <= cache_beat + 6'd1;
            end
            cache_gap <= cah_ready ? 8'd1 : cache_gap + 8'd1;
        end
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------

    a_load_time: assert property (@(posedge clock) disable iff (reset)
        load_busy |-> (reg_valid == (busy_cycles == ram_latency + 2)))
        else stop_on_error("load beat missing or off its latency");

    a_load_data: assert property (@(posedge clock) disable iff (reset)
        (load_busy && reg_valid) |-> (reg_data == exp_load && reg_addr == exp_rd))
        else stop_on_error("load data or destination register wrong");

    a_nonmem: assert property (@(posedge clock) disable iff (reset)
        (exu_valid && exu_ready && !exu_men) |->
            (reg_valid == exu_gen && csr_valid == exu_sen &&
             reg_addr == exu_ard && reg_data == exu_rd &&
             csr_addr == exu_acsr && csr_data == exu_csr))
        else stop_on_error("non-memory write-back wrong");

    a_busy_ready: assert property (@(posedge clock) disable iff (reset)
        (load_busy || store_busy) |-> !exu_ready)
        else stop_on_error("exu_ready high during memory operation");

    a_store_quiet: assert property (@(posedge clock) disable iff (reset)
        store_busy |-> !reg_valid)
        else stop_on_error("reg_valid during store");

    // write completes lat+1 after lsu_wvalid, arbiter frees one cycle later
    a_store_done: assert property (@(posedge clock) disable iff (reset)
        (store_busy && busy_cycles == ram_latency + 2) |=> (exu_ready || cah_valid))
        else stop_on_error("store did not complete on time");

    a_cache_prio: assert property (@(posedge clock) disable iff (reset)
        (cah_valid && (exu_men || erri)) |-> !exu_ready)
        else stop_on_error("memory operation not held off by cache");

    a_cache_data: assert property (@(posedge clock) disable iff (reset)
        cah_ready |-> (cah_data == cache_exp))
        else stop_on_error("cache beat data wrong");

    a_cache_idle: assert property (@(posedge clock) disable iff (reset)
        !cah_ready |-> (cah_data == '0))
        else stop_on_error("cah_data nonzero without a beat");

    a_cache_gap: assert property (@(posedge clock) disable iff (reset)
        (cah_ready && cache_beat != 0) |-> (cache_gap == ram_latency + 1))
        else stop_on_error("burst beat spacing wrong");

    a_err: assert property (@(posedge clock) disable iff (reset)
        (erro == (exu_valid && exu_ready && erri)) && (errtpo == errtpi))
        else stop_on_error("error outputs wrong");

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------

    // presents one operation and waits for its handshake
    task automatic issue(input logic men, input logic write, input logic [31:0] addr,
                         input logic [1:0] mask, input logic [31:0] data);
        logic [31:0] r;
        r = $random(seed);
        exu_men   <= men;
        exu_write <= write;
        exu_addr  <= addr;
        exu_mask  <= mask;
        exu_wdata <= data;
        exu_rd    <= data;
        exu_csr   <= ~data;
        exu_rsign <= r[0];
        exu_gen   <= r[1];
        exu_sen   <= r[2];
        erri      <= &r[5:3];
        errtpi    <= r[9:6];
        exu_ard   <= r[14:10];
        exu_acsr  <= r[26:15];
        exu_valid <= 1'b1;
        @(posedge clock);
        while (!exu_ready) begin
            @(posedge clock);
        end
        exu_valid <= 1'b0;
    endtask

    task automatic random_op();
        logic [31:0] r;
        logic [31:0] addr;
        logic [1:0]  mask;
        r    = $random(seed);
        mask = r[1:0];
        addr = {24'd0, r[9:2]};
        if (mask == size_half) begin
            addr[0] = 1'b0;
        end else if (mask != size_byte) begin
            addr[1:0] = 2'b00;
        end
        issue(r[11:10] != 2'b00, r[12], addr, mask, $random(seed));
    endtask

    // holds cah_valid until every beat has been seen
    task automatic fetch_burst(input logic [31:0] start, input logic [7:0] rlen,
                               input logic burst);
        int beats;
        int seen;
        beats = burst ? int'(rlen) + 1 : 1;
        seen  = 0;
        cah_addr  <= start;
        cah_rlen  <= rlen;
        cah_burst <= burst;
        cah_valid <= 1'b1;
        while (seen < beats) begin
            @(posedge clock);
            if (cah_ready) begin
                seen++;
            end
        end
        cah_valid <= 1'b0;
        @(posedge clock);
    endtask

    initial begin
        logic [31:0] r;
        logic [5:0]  idx;
        reset     = 1'b1;
        cah_valid = 1'b0;
        cah_addr  = '0;
        cah_burst = 1'b0;
        cah_rlen  = '0;
        exu_valid = 1'b0;
        exu_men   = 1'b0;
        exu_ard   = '0;
        exu_rd    = '0;
        exu_gen   = 1'b0;
        exu_acsr  = '0;
        exu_csr   = '0;
        exu_sen   = 1'b0;
        exu_write = 1'b0;
        exu_wdata = '0;
        exu_addr  = '0;
        exu_mask  = size_word;
        exu_rsign = 1'b0;
        erri      = 1'b0;
        errtpi    = '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        // every model word gets a defined value first
        for (int i = 0; i < num_fill; i++) begin
            issue(1'b1, 1'b1, i * 4, size_word, fill_word(i * 4));
        end

        for (int n = 0; n < num_rand; n++) begin
            r = $random(seed);
            if (r[2:0] == 3'd0) begin
                idx = (r[8:3] > 6'd60) ? 6'd60 : r[8:3];
                fork
                    fetch_burst({24'd0, idx, 2'b00}, {6'd0, r[10:9]}, r[11]);
                    begin
                        @(posedge clock);
                        random_op();
                    end
                join
            end else begin
                random_op();
            end
        end

        // let the last operation retire
        @(posedge clock);
        while (!exu_ready) begin
            @(posedge clock);
        end
        repeat (4) @(posedge clock);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* src.f */
core_mem_pkg.sv
data_ram.sv
load_store_unit.sv
mem_arbiter.sv
mem_subsystem.sv
mem_subsystem_tb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --assert -Wno-fatal -j 0
TOP       := mem_subsystem_tb
FILELIST  := src.f

OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
